// File: src/otp_part_pkg.sv
// Geometry and codes for one fixed 64-byte OTP partition of eight 64-bit blocks
// The last block holds the digest, and NumBlocks must be a power of two
// OTP addresses are 16-bit words, hence the shift by one from byte addresses

package otp_part_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Partition geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned BlockWidth = 64;
  localparam int unsigned NumBlocks = 8;
  localparam int unsigned CntWidth = 3;
  localparam int unsigned PartDataWidth = NumBlocks * BlockWidth;

  // Byte and word addressing towards the macro
  localparam int unsigned OtpByteAddrWidth = 12;
  localparam int unsigned OtpAddrShift = 1;
  localparam int unsigned OtpAddrWidth = 11;
  localparam logic [OtpByteAddrWidth-1:0] PartOffset = 12'h040;

  // Transfer size is in 16-bit words minus one
  localparam int unsigned OtpSizeWidth = 2;
  localparam logic [OtpSizeWidth-1:0] OtpBlockSize = 2'd3;

  // Non-zero digest locks the partition for software
  localparam bit DigestReadLock = 1'b1;
  localparam bit DigestWriteLock = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Error codes and macro commands
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // ReadRaw skips ECC decoding in the macro
  typedef enum logic {
    Read    = 1'b0,
    ReadRaw = 1'b1
  } otp_cmd_e;

endpackage : otp_part_pkg

// File: src/otp_buf_if.sv
// Write and read port of the block buffer, as seen from the partition FSM
// rdata and par_err are combinational, a write lands on the next edge

`timescale 1ns/1ps

interface otp_buf_if
  import otp_part_pkg::*;
();

  // Write strobe and block index
  logic                  wr_en;
  logic [CntWidth-1:0]   addr;
  logic [BlockWidth-1:0] wdata;
  // Block at addr
  logic [BlockWidth-1:0] rdata;
  // Parity mismatch in any stored block
  logic                  par_err;

  modport fsm (
    output wr_en, addr, wdata,
    input  rdata, par_err
  );

  // Storage side
  modport buffer (
    input  wr_en, addr, wdata,
    output rdata, par_err
  );

endinterface : otp_buf_if

// File: src/otp_part_cnt.sv
// Block counter kept twice, once counting up from zero and once down from max
// The sum of both must always equal max, else err_o flags a fault
// Never incremented past NumBlocks-1 by the FSM

`timescale 1ns/1ps

module otp_part_cnt
  import otp_part_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,
  input  logic                en_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                err_o
);

  logic [CntWidth-1:0] up_q;
  logic [CntWidth-1:0] dn_q;

  // Clear wins over enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q <= '0;
      dn_q <= CntWidth'(NumBlocks - 1);
    end else if (clr_i) begin
      up_q <= '0;
      dn_q <= CntWidth'(NumBlocks - 1);
    end else if (en_i) begin
      up_q <= up_q + 1'b1;
      dn_q <= dn_q - 1'b1;
    end
  end

  assign cnt_o = up_q;

  // Up plus down is constant as long as both copies move in step
  assign err_o = CntWidth'(up_q + dn_q) != CntWidth'(NumBlocks - 1);

endmodule : otp_part_cnt

// File: src/otp_part_buffer.sv
// Eight-block buffer, one even parity bit per block
// Cleared to zero at reset, which is a parity-consistent value
// Digest is the top block and is never gated here

`timescale 1ns/1ps

module otp_part_buffer
  import otp_part_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  otp_buf_if.buffer                buf_i,
  output logic [PartDataWidth-1:0] data_o,
  output logic [BlockWidth-1:0]    digest_o
);

  logic [BlockWidth-1:0] data_q [NumBlocks];
  logic [NumBlocks-1:0]  par_q;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumBlocks; i++) begin
        data_q[i] <= '0;
      end
      par_q <= '0;
    end else if (buf_i.wr_en) begin
      data_q[buf_i.addr] <= buf_i.wdata;
      // Parity taken on the way in
      par_q[buf_i.addr]  <= ^buf_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  assign buf_i.rdata = data_q[buf_i.addr];

  // Every block is checked all the time, not just the addressed one
  always_comb begin
    buf_i.par_err = 1'b0;
    for (int i = 0; i < NumBlocks; i++) begin
      buf_i.par_err = buf_i.par_err | ((^data_q[i]) ^ par_q[i]);
    end
  end

  // Block 0 sits in the low bits
  always_comb begin
    data_o = '0;
    for (int i = 0; i < NumBlocks; i++) begin
      data_o[i*BlockWidth +: BlockWidth] = data_q[i];
    end
  end

  assign digest_o = data_q[NumBlocks-1];

endmodule : otp_part_buffer

// File: src/otp_part_lock.sv
// Lock aggregation for software access, registered one cycle
// Locks reset to 1 and stay high until the partition is released
// Data output is zero while the FSM holds the partition locked

`timescale 1ns/1ps

module otp_part_lock
  import otp_part_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     locked_i,
  input  logic                     read_lock_i,
  input  logic                     write_lock_i,
  input  logic [PartDataWidth-1:0] data_i,
  input  logic [BlockWidth-1:0]    digest_i,
  output logic                     read_lock_o,
  output logic                     write_lock_o,
  output logic                     init_done_o,
  output logic [PartDataWidth-1:0] data_o
);

  logic digest_set;
  logic read_lock_d;
  logic write_lock_d;

  // Any non-zero digest counts as a finalized partition
  assign digest_set = |digest_i;

  assign read_lock_d  = read_lock_i | locked_i | (DigestReadLock & digest_set);
  assign write_lock_d = write_lock_i | locked_i | (DigestWriteLock & digest_set);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_lock_o  <= 1'b1;
      write_lock_o <= 1'b1;
    end else begin
      read_lock_o  <= read_lock_d;
      write_lock_o <= write_lock_d;
    end
  end

  // Released data only
  assign init_done_o = ~locked_i;
  assign data_o      = locked_i ? '0 : data_i;

endmodule : otp_part_lock

// File: src/otp_part_fsm.sv
// Partition FSM for init readout, background consistency check and terminal error
// One OTP transaction at a time with the request held until grant
// Error state is only left by reset, and acks are held high there

`timescale 1ns/1ps

module otp_part_fsm
  import otp_part_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        init_req_i,
  input  logic                        cnsty_chk_req_i,
  input  logic                        escalate_en_i,
  input  logic                        check_byp_en_i,
  output logic                        cnsty_chk_ack_o,
  output otp_err_e                    error_o,
  output logic                        fsm_err_o,
  output logic                        locked_o,
  // OTP macro port
  output logic                        otp_req_o,
  output otp_cmd_e                    otp_cmd_o,
  output logic [OtpSizeWidth-1:0]     otp_size_o,
  output logic [OtpAddrWidth-1:0]     otp_addr_o,
  input  logic                        otp_gnt_i,
  input  logic                        otp_rvalid_i,
  input  logic [BlockWidth-1:0]       otp_rdata_i,
  input  otp_err_e                    otp_err_i,
  // Block counter
  input  logic [CntWidth-1:0]         cnt_i,
  input  logic                        cnt_err_i,
  output logic                        cnt_clr_o,
  output logic                        cnt_en_o,
  // Buffer port
  otp_buf_if.fsm                      buf_o
);

  // Sparse encoding with minimum Hamming distance 3
  typedef enum logic [7:0] {
    ResetSt         = 8'b1011_0010,
    InitSt          = 8'b0110_1100,
    InitWaitSt      = 8'b1100_0111,
    IdleSt          = 8'b0001_1011,
    CnstyReadSt     = 8'b1010_1101,
    CnstyReadWaitSt = 8'b0111_0001,
    ErrorSt         = 8'b1101_1110
  } state_e;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  logic     locked_d, locked_q;
  logic     last_blk;
  logic     blk_match;
  logic     otp_ok;
  logic [OtpByteAddrWidth-1:0] byte_addr;

  assign last_blk  = cnt_i == CntWidth'(NumBlocks - 1);
  assign blk_match = otp_rdata_i == buf_o.rdata;
  // Correctable ECC hits still deliver good data
  assign otp_ok    = otp_err_i inside {NoError, MacroEccCorrError};

  ////////////////////////////////////////////////////////////////////////////
  // Next state logic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    locked_d        = locked_q;
    otp_req_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_o.wr_en     = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one init pulse after power up
      ResetSt: begin
        if (init_req_i) begin
          state_d   = InitSt;
          cnt_clr_o = 1'b1;
        end
      end
      // Hold the request until the macro takes it
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Store the returned block, then next block or release
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (otp_ok) begin
            buf_o.wr_en = 1'b1;
            if (last_blk) begin
              state_d  = IdleSt;
              locked_d = 1'b0;
            end else begin
              state_d  = InitSt;
              cnt_en_o = 1'b1;
            end
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          state_d   = CnstyReadSt;
          cnt_clr_o = 1'b1;
        end
      end
      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = CnstyReadWaitSt;
        end
      end
      // Compare against the buffer unless the compare is bypassed
      CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (otp_ok) begin
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
            if (blk_match || check_byp_en_i) begin
              if (last_blk) begin
                state_d         = IdleSt;
                cnsty_chk_ack_o = 1'b1;
              end else begin
                state_d  = CnstyReadSt;
                cnt_en_o = 1'b1;
              end
            end else begin
              state_d         = ErrorSt;
              error_d         = CheckFailError;
              cnsty_chk_ack_o = 1'b1;
            end
          end else begin
            state_d         = ErrorSt;
            error_d         = otp_err_i;
            cnsty_chk_ack_o = 1'b1;
          end
        end
      end
      // Terminal state with data locked down and checks answered at once
      ErrorSt: begin
        locked_d        = 1'b1;
        cnsty_chk_ack_o = 1'b1;
      end
      // Glitched into an unused encoding
      default: begin
        state_d   = ErrorSt;
        error_d   = FsmStateError;
        fsm_err_o = 1'b1;
      end
    endcase

    // Buffer corruption
    if (buf_o.par_err) begin
      state_d = ErrorSt;
      if (state_q != ErrorSt) begin
        error_d = CheckFailError;
      end
    end

    // Escalation or counter fault overrides everything
    if (escalate_en_i || cnt_err_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and datapath
  ////////////////////////////////////////////////////////////////////////////

  // Blocks are 8 bytes apart and the macro takes 16-bit word addresses
  assign byte_addr  = PartOffset + OtpByteAddrWidth'({cnt_i, {$clog2(BlockWidth/8){1'b0}}});
  assign otp_addr_o = OtpAddrWidth'(byte_addr >> OtpAddrShift);
  assign otp_size_o = OtpBlockSize;
  assign otp_cmd_o  = Read;

  assign buf_o.addr  = cnt_i;
  assign buf_o.wdata = otp_rdata_i;

  assign error_o  = error_q;
  assign locked_o = locked_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ResetSt;
      error_q  <= NoError;
      locked_q <= 1'b1;
    end else begin
      state_q  <= state_d;
      error_q  <= error_d;
      locked_q <= locked_d;
    end
  end

endmodule : otp_part_fsm

// File: src/otp_part_buf.sv
// Buffered OTP partition, 64 bytes at PartOffset, last block is the digest
// init_req_i is expected once per power cycle
// Escalation and lock inputs are single active-high bits

`timescale 1ns/1ps

module otp_part_buf
  import otp_part_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     init_req_i,
  output logic                     init_done_o,
  input  logic                     cnsty_chk_req_i,
  output logic                     cnsty_chk_ack_o,
  input  logic                     escalate_en_i,
  input  logic                     check_byp_en_i,
  output otp_err_e                 error_o,
  output logic                     fsm_err_o,
  // Software locks in, aggregated locks out
  input  logic                     read_lock_i,
  input  logic                     write_lock_i,
  output logic                     read_lock_o,
  output logic                     write_lock_o,
  output logic [BlockWidth-1:0]    digest_o,
  output logic [PartDataWidth-1:0] data_o,
  // OTP macro port
  output logic                     otp_req_o,
  output otp_cmd_e                 otp_cmd_o,
  output logic [OtpSizeWidth-1:0]  otp_size_o,
  output logic [OtpAddrWidth-1:0]  otp_addr_o,
  input  logic                     otp_gnt_i,
  input  logic                     otp_rvalid_i,
  input  logic [BlockWidth-1:0]    otp_rdata_i,
  input  otp_err_e                 otp_err_i
);

  logic                     locked;
  logic                     cnt_clr;
  logic                     cnt_en;
  logic                     cnt_err;
  logic [CntWidth-1:0]      cnt;
  logic [PartDataWidth-1:0] buf_data;

  otp_buf_if u_buf_if ();

  otp_part_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .escalate_en_i   (escalate_en_i),
    .check_byp_en_i  (check_byp_en_i),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .locked_o        (locked),
    .otp_req_o       (otp_req_o),
    .otp_cmd_o       (otp_cmd_o),
    .otp_size_o      (otp_size_o),
    .otp_addr_o      (otp_addr_o),
    .otp_gnt_i       (otp_gnt_i),
    .otp_rvalid_i    (otp_rvalid_i),
    .otp_rdata_i     (otp_rdata_i),
    .otp_err_i       (otp_err_i),
    .cnt_i           (cnt),
    .cnt_err_i       (cnt_err),
    .cnt_clr_o       (cnt_clr),
    .cnt_en_o        (cnt_en),
    .buf_o           (u_buf_if.fsm)
  );

  otp_part_cnt u_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .en_i   (cnt_en),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  otp_part_buffer u_buffer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .buf_i    (u_buf_if.buffer),
    .data_o   (buf_data),
    .digest_o (digest_o)
  );

  otp_part_lock u_lock (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .locked_i     (locked),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .data_i       (buf_data),
    .digest_i     (digest_o),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o),
    .init_done_o  (init_done_o),
    .data_o       (data_o)
  );

endmodule : otp_part_buf

// File: verif/otp_part_buf_asserts.sv
// Concurrent checks on the partition top level, bound into every otp_part_buf
// Lock outputs trail the release flag by one cycle, the lock check allows that

`timescale 1ns/1ps

module otp_part_buf_asserts
  import otp_part_pkg::*;
(
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    init_done_o,
  input logic                    read_lock_o,
  input logic                    write_lock_o,
  input logic                    otp_req_o,
  input logic                    otp_gnt_i,
  input logic [OtpAddrWidth-1:0] otp_addr_o,
  input otp_err_e                error_o
);

  int unsigned fail_cnt = 0;

  // Held partition for two cycles means both locks are up
  locks_while_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!init_done_o && $past(!init_done_o)) |-> (read_lock_o && write_lock_o))
  else begin
    $error("lock output low while the partition is held");
    fail_cnt++;
  end

  // Request and address frozen until the macro grants
  req_held_to_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (otp_req_o && !otp_gnt_i) |=> (otp_req_o && $stable(otp_addr_o)))
  else begin
    $error("OTP request dropped or address moved before grant");
    fail_cnt++;
  end

  // Terminal error never releases the data
  err_keeps_locked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (error_o != NoError && error_o != MacroEccCorrError) |=> !init_done_o)
  else begin
    $error("init_done_o high in the error state");
    fail_cnt++;
  end

endmodule : otp_part_buf_asserts

bind otp_part_buf otp_part_buf_asserts i_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .init_done_o  (init_done_o),
  .read_lock_o  (read_lock_o),
  .write_lock_o (write_lock_o),
  .otp_req_o    (otp_req_o),
  .otp_gnt_i    (otp_gnt_i),
  .otp_addr_o   (otp_addr_o),
  .error_o      (error_o)
);

// File: verif/tb_otp_part_buf.sv
// Directed test of the buffered OTP partition against a behavioral OTP macro
// Grant and read-valid delays are 1 to 4 cycles from a fixed-seed Galois LFSR
// One reset per table row and the whole run is bounded by a watchdog

`timescale 1ns/1ps

module tb_otp_part_buf
  import otp_part_pkg::*;
();

  localparam int unsigned ClkPeriod = 100;
  localparam int unsigned NumTests = 8;
  localparam logic [BlockWidth-1:0] CorruptMask = 64'h0000_0000_0002_0000;

  typedef struct packed {
    logic [PartDataWidth-1:0] contents;
    logic [CntWidth-1:0]      err_blk;
    otp_err_e                 err_code;
    logic                     corrupt_en;
    logic [CntWidth-1:0]      corrupt_blk;
    logic                     byp;
    logic                     esc;
    logic                     rd_lock;
    logic                     wr_lock;
    logic                     run_chk;
    otp_err_e                 exp_err;
  } test_row_t;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     init_req_i;
  logic                     init_done_o;
  logic                     cnsty_chk_req_i;
  logic                     cnsty_chk_ack_o;
  logic                     escalate_en_i;
  logic                     check_byp_en_i;
  otp_err_e                 error_o;
  logic                     fsm_err_o;
  logic                     read_lock_i;
  logic                     write_lock_i;
  logic                     read_lock_o;
  logic                     write_lock_o;
  logic [BlockWidth-1:0]    digest_o;
  logic [PartDataWidth-1:0] data_o;
  logic                     otp_req_o;
  otp_cmd_e                 otp_cmd_o;
  logic [OtpSizeWidth-1:0]  otp_size_o;
  logic [OtpAddrWidth-1:0]  otp_addr_o;
  logic                     otp_gnt_i;
  logic                     otp_rvalid_i;
  logic [BlockWidth-1:0]    otp_rdata_i;
  otp_err_e                 otp_err_i;

  // OTP model state shared with the test sequence
  logic [BlockWidth-1:0] otp_mem [NumBlocks];
  logic [CntWidth-1:0]   next_blk;
  logic [CntWidth-1:0]   inj_blk;
  otp_err_e              inj_code;
  logic                  inj_armed;
  logic [31:0]           lfsr_state = 32'h5512_42be;

  test_row_t   rows [NumTests];
  string       names [NumTests];
  int unsigned n_rows = 0;
  int unsigned err_cnt = 0;
  int unsigned n_pass = 0;
  int unsigned n_fail = 0;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  otp_part_buf i_dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Random delays and fill pattern
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic int unsigned rand_bits(input int unsigned width);
    int unsigned val;
    int unsigned k;
    val = 0;
    for (k = 0; k < width; k++) begin
      val = (val << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  // Every block depends on its full index and the digest may be forced to zero
  function automatic logic [PartDataWidth-1:0] make_part(input logic [63:0] base,
                                                         input bit zero_digest);
    logic [PartDataWidth-1:0] part;
    int i;
    part = '0;
    for (i = 0; i < NumBlocks; i++) begin
      part[i*BlockWidth +: BlockWidth] = base ^ (64'h9e37_79b9_7f4a_7c15 * (i + 1));
    end
    if (zero_digest) begin
      part[(NumBlocks-1)*BlockWidth +: BlockWidth] = '0;
    end
    return part;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic block_cmp(input string name, input logic [BlockWidth-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic data_cmp(input string name, input logic [PartDataWidth-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic err_cmp(input string name, input otp_err_e got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmd_cmp(input string name, input otp_cmd_e got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic flag_cmp(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic addr_cmp(input string name, input logic [OtpAddrWidth-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic size_cmp(input string name, input logic [OtpSizeWidth-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // OTP macro model
  ////////////////////////////////////////////////////////////////////////////

  // One transaction at a time with blocks expected in order from block 0
  initial begin : otp_model
    int unsigned gnt_dly;
    int unsigned rsp_dly;
    logic [OtpAddrWidth-1:0] exp_addr;
    otp_gnt_i    <= 1'b0;
    otp_rvalid_i <= 1'b0;
    otp_rdata_i  <= '0;
    otp_err_i    <= NoError;
    next_blk     = '0;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        next_blk = '0;
      end else if (otp_req_o) begin
        exp_addr = OtpAddrWidth'((PartOffset + 12'(8 * int'(next_blk))) >> OtpAddrShift);
        addr_cmp("otp_addr_o", otp_addr_o, exp_addr);
        size_cmp("otp_size_o", otp_size_o, OtpBlockSize);
        cmd_cmp("otp_cmd_o", otp_cmd_o, Read);
        gnt_dly = rand_bits(2) + 1;
        rsp_dly = rand_bits(2) + 1;
        repeat (gnt_dly) @(posedge clk_i);
        otp_gnt_i <= 1'b1;
        @(posedge clk_i);
        otp_gnt_i <= 1'b0;
        repeat (rsp_dly - 1) @(posedge clk_i);
        otp_rvalid_i <= 1'b1;
        otp_rdata_i  <= otp_mem[next_blk];
        if (inj_armed && next_blk == inj_blk) begin
          otp_err_i <= inj_code;
          inj_armed = 1'b0;
        end
        @(posedge clk_i);
        otp_rvalid_i <= 1'b0;
        otp_err_i    <= NoError;
        next_blk     = next_blk + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [63:0] base, input bit zero_digest,
                         input int err_blk, input otp_err_e err_code, input bit corrupt_en,
                         input int corrupt_blk, input bit byp, input bit esc,
                         input bit rd_lock, input bit wr_lock, input bit run_chk,
                         input otp_err_e exp_err);
    names[n_rows]            = name;
    rows[n_rows].contents    = make_part(base, zero_digest);
    rows[n_rows].err_blk     = CntWidth'(err_blk);
    rows[n_rows].err_code    = err_code;
    rows[n_rows].corrupt_en  = corrupt_en;
    rows[n_rows].corrupt_blk = CntWidth'(corrupt_blk);
    rows[n_rows].byp         = byp;
    rows[n_rows].esc         = esc;
    rows[n_rows].rd_lock     = rd_lock;
    rows[n_rows].wr_lock     = wr_lock;
    rows[n_rows].run_chk     = run_chk;
    rows[n_rows].exp_err     = exp_err;
    n_rows++;
  endtask

  // Columns are name, base, zero digest, error block, error code, corrupt, corrupt block,
  // bypass, escalate, sw read lock, sw write lock, run check and expected error
  task automatic build_table();
    add_row("clean init, zero digest", 64'h0123_4567_89ab_cdef, 1, 0, NoError,
            0, 0, 0, 0, 0, 0, 1, NoError);
    add_row("clean init, digest set", 64'hfeed_0000_c0de_1234, 0, 0, NoError,
            0, 0, 0, 0, 0, 0, 1, NoError);
    add_row("check after corruption", 64'h5a5a_1111_2222_3333, 1, 0, NoError,
            1, 2, 0, 0, 0, 0, 1, CheckFailError);
    add_row("corruption, bypass", 64'h7777_8888_9999_aaaa, 1, 0, NoError,
            1, 5, 1, 0, 0, 0, 1, NoError);
    add_row("correctable ECC in init", 64'h0f0f_f0f0_3c3c_c3c3, 1, 3, MacroEccCorrError,
            0, 0, 0, 0, 0, 0, 1, MacroEccCorrError);
    add_row("uncorrectable ECC in init", 64'hdead_beef_0bad_f00d, 1, 5, MacroEccUncorrError,
            0, 0, 0, 0, 0, 0, 0, MacroEccUncorrError);
    add_row("escalation after init", 64'h1357_9bdf_2468_ace0, 1, 0, NoError,
            0, 0, 0, 1, 0, 0, 1, FsmStateError);
    add_row("sw read lock only", 64'hcafe_f00d_1234_5678, 1, 0, NoError,
            0, 0, 0, 0, 1, 0, 1, NoError);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset(input logic byp, input logic rd_lock, input logic wr_lock);
    @(posedge clk_i);
    rst_ni          <= 1'b0;
    init_req_i      <= 1'b0;
    cnsty_chk_req_i <= 1'b0;
    escalate_en_i   <= 1'b0;
    check_byp_en_i  <= byp;
    read_lock_i     <= rd_lock;
    write_lock_i    <= wr_lock;
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    flag_cmp("otp_req_o", otp_req_o, 1'b0);
    flag_cmp("init_done_o", init_done_o, 1'b0);
    flag_cmp("cnsty_chk_ack_o", cnsty_chk_ack_o, 1'b0);
    flag_cmp("fsm_err_o", fsm_err_o, 1'b0);
    err_cmp("error_o", error_o, NoError);
    flag_cmp("read_lock_o", read_lock_o, 1'b1);
    flag_cmp("write_lock_o", write_lock_o, 1'b1);
    @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic run_test(input int idx);
    test_row_t row;
    int unsigned errs_at_start;
    int n;
    int i;
    logic [BlockWidth-1:0] exp_digest;
    logic init_ok;
    logic exp_dead;
    logic digest_set;
    row           = rows[idx];
    errs_at_start = err_cnt;
    exp_digest    = row.contents[(NumBlocks-1)*BlockWidth +: BlockWidth];
    digest_set    = |exp_digest;
    init_ok       = row.err_code inside {NoError, MacroEccCorrError};
    exp_dead      = !(row.exp_err inside {NoError, MacroEccCorrError});

    // Macro image and injected error
    for (i = 0; i < NumBlocks; i++) begin
      otp_mem[i] = row.contents[i*BlockWidth +: BlockWidth];
    end
    inj_blk   = row.err_blk;
    inj_code  = row.err_code;
    inj_armed = row.err_code != NoError;
    apply_reset(row.byp, row.rd_lock, row.wr_lock);

    @(posedge clk_i);
    init_req_i <= 1'b1;
    @(posedge clk_i);
    init_req_i <= 1'b0;
    @(negedge clk_i);
    while (!init_done_o && error_o inside {NoError, MacroEccCorrError}) begin
      @(negedge clk_i);
    end
    if (init_ok) begin
      flag_cmp("init_done_o", init_done_o, 1'b1);
      data_cmp("data_o", data_o, row.contents);
      block_cmp("digest_o", digest_o, exp_digest);
      err_cmp("error_o", error_o, row.err_code);
    end else begin
      // Done must stay low for good
      repeat (20) @(negedge clk_i);
    end

    if (row.corrupt_en) begin
      otp_mem[row.corrupt_blk] = otp_mem[row.corrupt_blk] ^ CorruptMask;
    end

    if (row.esc) begin
      @(posedge clk_i);
      escalate_en_i <= 1'b1;
      @(negedge clk_i);
      flag_cmp("fsm_err_o", fsm_err_o, 1'b1);
      @(posedge clk_i);
      escalate_en_i <= 1'b0;
    end

    if (row.run_chk) begin
      @(posedge clk_i);
      cnsty_chk_req_i <= 1'b1;
      @(negedge clk_i);
      // Error state answers at once
      if (row.esc) begin
        flag_cmp("cnsty_chk_ack_o", cnsty_chk_ack_o, 1'b1);
      end
      while (!cnsty_chk_ack_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      cnsty_chk_req_i <= 1'b0;
    end

    // Let error, release flag and locks settle
    @(negedge clk_i);
    for (n = 0; n < 8 && exp_dead && init_done_o; n++) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    err_cmp("error_o", error_o, row.exp_err);
    flag_cmp("init_done_o", init_done_o, !exp_dead);
    data_cmp("data_o", data_o, exp_dead ? '0 : row.contents);
    flag_cmp("read_lock_o", read_lock_o,
             row.rd_lock | exp_dead | (DigestReadLock & digest_set));
    flag_cmp("write_lock_o", write_lock_o,
             row.wr_lock | exp_dead | (DigestWriteLock & digest_set));

    if (err_cnt == errs_at_start) begin
      n_pass++;
      $display("test %0d (%s): pass", idx, names[idx]);
    end else begin
      n_fail++;
      $display("test %0d (%s): fail, %0d errors", idx, names[idx], err_cnt - errs_at_start);
    end
  endtask

  initial begin : main
    int idx;
    int unsigned asrt_fails;
    rst_ni          <= 1'b0;
    init_req_i      <= 1'b0;
    cnsty_chk_req_i <= 1'b0;
    escalate_en_i   <= 1'b0;
    check_byp_en_i  <= 1'b0;
    read_lock_i     <= 1'b0;
    write_lock_i    <= 1'b0;
    inj_armed       = 1'b0;
    build_table();
    for (idx = 0; idx < NumTests; idx++) begin
      run_test(idx);
    end
    asrt_fails = i_dut.i_asserts.fail_cnt;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
             NumTests, n_pass, n_fail, asrt_fails);
    if (n_fail == 0 && asrt_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // About 200 cycles per table row is ample for reset, init and one check
  initial begin : watchdog
    #(NumTests * 200 * ClkPeriod);
    $display("timeout: run did not complete within %0d cycles", NumTests * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_otp_part_buf

// File: otp_part_buf.f
src/otp_part_pkg.sv
src/otp_buf_if.sv
src/otp_part_cnt.sv
src/otp_part_buffer.sv
src/otp_part_lock.sv
src/otp_part_fsm.sv
src/otp_part_buf.sv
verif/otp_part_buf_asserts.sv
verif/tb_otp_part_buf.sv
